// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_exec_core
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+include
source/exec_pkg.sv
source/alu_exec.sv
source/mul_exec.sv
source/result_queue.sv
source/cdb_arbiter.sv
source/arf_writeback.sv
source/exec_core_top.sv
verif/tb_exec_core.sv

// ==== include/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// datapath
`define XLEN 32
`define REG_COUNT 32
`define TAG_W 16 // stands in for the debug pc

// queues and pipes
`define RESULT_QUEUE_DEPTH 2
`define MUL_STAGES 3

// common data bus
`define FU_COUNT 3 // alu0, alu1, mul
`define CDB_COUNT 2 // dual commit

`endif

// ==== source/alu_exec.sv ====
`include "exec_settings.svh"

module alu_exec
    import exec_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  issue_pkt_t pkt_i,
    output logic       ready_o,
    output logic       valid_o,
    output cdb_pkt_t   result_o,
    input  logic       ready_i
);

    localparam int SHAMT_W = $clog2(`XLEN);

    word_t    alu_res;
    logic     valid_q;
    cdb_pkt_t result_q;

    always_comb begin
        case (pkt_i.op)
            ALU_ADD: alu_res = pkt_i.src_a + pkt_i.src_b;
            ALU_SUB: alu_res = pkt_i.src_a - pkt_i.src_b;
            ALU_AND: alu_res = pkt_i.src_a & pkt_i.src_b;
            ALU_OR:  alu_res = pkt_i.src_a | pkt_i.src_b;
            ALU_XOR: alu_res = pkt_i.src_a ^ pkt_i.src_b;
            ALU_SLL: alu_res = pkt_i.src_a << pkt_i.src_b[SHAMT_W-1:0];
            ALU_SRL: alu_res = pkt_i.src_a >> pkt_i.src_b[SHAMT_W-1:0];
            ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(pkt_i.src_a) < $signed(pkt_i.src_b)};
            default: alu_res = '0;
        endcase
    end

    // output reg empty or leaving this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (valid_i && ready_o) begin
            result_q.w_data <= alu_res;
            result_q.dest   <= pkt_i.dest;
            result_q.tag    <= pkt_i.tag;
        end
    end

    assign valid_o  = valid_q;
    assign result_o = result_q;

    // queue may stall us, result must not change meanwhile
    a_hold_result: assert property (@(posedge aclk) disable iff (!rst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(result_o));

endmodule

// ==== source/arf_writeback.sv ====
`include "exec_settings.svh"

module arf_writeback
    import exec_pkg::*;
(
    input  logic                       aclk,
    input  logic                       rst_n_i,
    input  logic     [`CDB_COUNT-1:0]  slot_valid_i,
    input  cdb_pkt_t [`CDB_COUNT-1:0]  slot_pkt_i,
    input  reg_idx_t                   reg_num_i,
    output word_t                      rf_rdata_o,
    output tag_t                       debug0_wb_pc_o,
    output logic                       debug0_wb_rf_wen_o,
    output reg_idx_t                   debug0_wb_rf_wnum_o,
    output word_t                      debug0_wb_rf_wdata_o,
    output tag_t                       debug1_wb_pc_o,
    output logic                       debug1_wb_rf_wen_o,
    output reg_idx_t                   debug1_wb_rf_wnum_o,
    output word_t                      debug1_wb_rf_wdata_o
);

    word_t rf_q [`REG_COUNT];

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `REG_COUNT; r++) rf_q[r] <= '0;
        end else begin
            // later slot overrides on same dest
            for (int s = 0; s < `CDB_COUNT; s++) begin
                if (slot_valid_i[s] && slot_pkt_i[s].dest != '0) begin
                    rf_q[slot_pkt_i[s].dest] <= slot_pkt_i[s].w_data;
                end
            end
        end
    end

    assign rf_rdata_o = rf_q[reg_num_i]; // r0 never written

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            debug0_wb_rf_wen_o <= 1'b0;
            debug1_wb_rf_wen_o <= 1'b0;
        end else begin
            debug0_wb_rf_wen_o <= slot_valid_i[0];
            debug1_wb_rf_wen_o <= slot_valid_i[1];
        end
    end

    // r0 writes still show up here
    always_ff @(posedge aclk) begin
        debug0_wb_pc_o       <= slot_pkt_i[0].tag;
        debug0_wb_rf_wnum_o  <= slot_pkt_i[0].dest;
        debug0_wb_rf_wdata_o <= slot_pkt_i[0].w_data;
        debug1_wb_pc_o       <= slot_pkt_i[1].tag;
        debug1_wb_rf_wnum_o  <= slot_pkt_i[1].dest;
        debug1_wb_rf_wdata_o <= slot_pkt_i[1].w_data;
    end

endmodule

// ==== source/cdb_arbiter.sv ====
`include "exec_settings.svh"

module cdb_arbiter
    import exec_pkg::*;
(
    input  logic                           aclk,
    input  logic                           rst_n_i,
    input  logic     [`FU_COUNT-1:0]       src_valid_i,
    input  cdb_pkt_t [`FU_COUNT-1:0]       src_pkt_i,
    output logic     [`FU_COUNT-1:0]       src_ready_o,
    output logic     [`CDB_COUNT-1:0]      slot_valid_o,
    output cdb_pkt_t [`CDB_COUNT-1:0]      slot_pkt_o
);

    localparam int SRC_W = $clog2(`FU_COUNT);
    localparam int CNT_W = $clog2(`CDB_COUNT + 1);

    logic [SRC_W-1:0]     ptr_q;   // first source to look at
    logic [SRC_W-1:0]     nxt_ptr;
    logic [SRC_W-1:0]     sel [`CDB_COUNT];
    logic [`FU_COUNT-1:0] grant;
    logic [CNT_W-1:0]     gnt_cnt;

    always_comb begin
        int unsigned idx;
        int unsigned n;
        grant   = '0;
        nxt_ptr = ptr_q;
        n       = 0;
        for (int s = 0; s < `CDB_COUNT; s++) begin
            sel[s] = '0;
        end
        // rotate from ptr_q and take the first valid ones
        for (int k = 0; k < `FU_COUNT; k++) begin
            idx = ptr_q + k;
            if (idx >= `FU_COUNT) idx = idx - `FU_COUNT;
            if (src_valid_i[idx] && n < `CDB_COUNT) begin
                grant[idx] = 1'b1;
                sel[n]     = SRC_W'(idx);
                nxt_ptr    = (idx == `FU_COUNT - 1) ? '0 : SRC_W'(idx + 1);
                n          = n + 1;
            end
        end
        gnt_cnt = CNT_W'(n);
    end

    assign src_ready_o = grant; // pop on the same edge

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q        <= '0;
            slot_valid_o <= '0;
        end else begin
            ptr_q <= nxt_ptr;
            for (int s = 0; s < `CDB_COUNT; s++) begin
                slot_valid_o[s] <= (gnt_cnt > CNT_W'(s)); // slots fill in order
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int s = 0; s < `CDB_COUNT; s++) begin
            slot_pkt_o[s] <= src_pkt_i[sel[s]];
        end
    end

    // each filled slot holds a different source
    a_distinct_grant: assert property (@(posedge aclk) disable iff (!rst_n_i)
        $countones(grant) == gnt_cnt);

endmodule

// ==== source/exec_core_top.sv ====
`include "exec_settings.svh"

module exec_core_top
    import exec_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n_i,
    input  logic       alu0_valid_i,
    input  issue_pkt_t alu0_pkt_i,
    output logic       alu0_ready_o,
    input  logic       alu1_valid_i,
    input  issue_pkt_t alu1_pkt_i,
    output logic       alu1_ready_o,
    input  logic       mul_valid_i,
    input  issue_pkt_t mul_pkt_i,
    output logic       mul_ready_o,
    input  reg_idx_t   reg_num_i,
    output word_t      rf_rdata_o,
    output tag_t       debug0_wb_pc_o,
    output logic       debug0_wb_rf_wen_o,
    output reg_idx_t   debug0_wb_rf_wnum_o,
    output word_t      debug0_wb_rf_wdata_o,
    output tag_t       debug1_wb_pc_o,
    output logic       debug1_wb_rf_wen_o,
    output reg_idx_t   debug1_wb_rf_wnum_o,
    output word_t      debug1_wb_rf_wdata_o
);

    // lane order on the bus: alu0, alu1, mul
    logic     [`FU_COUNT-1:0]  ex_valid;
    logic     [`FU_COUNT-1:0]  ex_ready;
    cdb_pkt_t [`FU_COUNT-1:0]  ex_pkt;
    logic     [`FU_COUNT-1:0]  q_valid;
    logic     [`FU_COUNT-1:0]  q_ready;
    cdb_pkt_t [`FU_COUNT-1:0]  q_pkt;
    logic     [`CDB_COUNT-1:0] slot_valid;
    cdb_pkt_t [`CDB_COUNT-1:0] slot_pkt;

    alu_exec u_alu0 (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .valid_i(alu0_valid_i), .pkt_i(alu0_pkt_i), .ready_o(alu0_ready_o),
        .valid_o(ex_valid[0]), .result_o(ex_pkt[0]), .ready_i(ex_ready[0])
    );

    alu_exec u_alu1 (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .valid_i(alu1_valid_i), .pkt_i(alu1_pkt_i), .ready_o(alu1_ready_o),
        .valid_o(ex_valid[1]), .result_o(ex_pkt[1]), .ready_i(ex_ready[1])
    );

    mul_exec u_mul (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .valid_i(mul_valid_i), .pkt_i(mul_pkt_i), .ready_o(mul_ready_o),
        .valid_o(ex_valid[2]), .result_o(ex_pkt[2]), .ready_i(ex_ready[2])
    );

    for (genvar i = 0; i < `FU_COUNT; i++) begin : g_rq
        result_queue #(.DEPTH(`RESULT_QUEUE_DEPTH), .T(cdb_pkt_t)) u_rq (
            .aclk(aclk), .rst_n_i(rst_n_i),
            .valid_i(ex_valid[i]), .data_i(ex_pkt[i]), .ready_o(ex_ready[i]),
            .valid_o(q_valid[i]), .data_o(q_pkt[i]), .ready_i(q_ready[i])
        );
    end

    cdb_arbiter u_cdb (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .src_valid_i(q_valid), .src_pkt_i(q_pkt), .src_ready_o(q_ready),
        .slot_valid_o(slot_valid), .slot_pkt_o(slot_pkt)
    );

    arf_writeback u_arf (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .slot_valid_i(slot_valid), .slot_pkt_i(slot_pkt),
        .reg_num_i(reg_num_i), .rf_rdata_o(rf_rdata_o),
        .debug0_wb_pc_o(debug0_wb_pc_o), .debug0_wb_rf_wen_o(debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o(debug0_wb_rf_wnum_o), .debug0_wb_rf_wdata_o(debug0_wb_rf_wdata_o),
        .debug1_wb_pc_o(debug1_wb_pc_o), .debug1_wb_rf_wen_o(debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o(debug1_wb_rf_wnum_o), .debug1_wb_rf_wdata_o(debug1_wb_rf_wdata_o)
    );

endmodule

// ==== source/exec_pkg.sv ====
`include "exec_settings.svh"

package exec_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
    typedef logic [`TAG_W-1:0] tag_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7  // signed compare
    } alu_op_e;

    // issued op, operands already read
    typedef struct packed {
        alu_op_e  op;    // mul lane ignores this
        word_t    src_a;
        word_t    src_b;
        reg_idx_t dest;
        tag_t     tag;
    } issue_pkt_t;

    // one result on the bus
    typedef struct packed {
        word_t    w_data;
        reg_idx_t dest;
        tag_t     tag;
    } cdb_pkt_t;

endpackage

// ==== source/mul_exec.sv ====
`include "exec_settings.svh"

module mul_exec
    import exec_pkg::*;
(
    input  logic       aclk,
    input  logic       rst_n_i,
    input  logic       valid_i,
    input  issue_pkt_t pkt_i,
    output logic       ready_o,
    output logic       valid_o,
    output cdb_pkt_t   result_o,
    input  logic       ready_i
);

    localparam int N    = `MUL_STAGES;
    localparam int HALF = `XLEN / 2;

    logic [N-1:0]    vld_q;
    tag_t            tag_q [N];
    reg_idx_t        dest_q [N];
    word_t           ll_q;    // lo x lo, full width
    logic [HALF-1:0] cross_q; // cross terms, only low half survives
    word_t           prod_q [1:N-1];
    word_t           ll_d;
    logic [HALF-1:0] cross_d;
    logic            adv;

    // stage 0 partial products
    assign ll_d    = pkt_i.src_a[HALF-1:0] * pkt_i.src_b[HALF-1:0];
    assign cross_d = pkt_i.src_a[HALF-1:0] * pkt_i.src_b[`XLEN-1:HALF]
                   + pkt_i.src_a[`XLEN-1:HALF] * pkt_i.src_b[HALF-1:0];

    // whole pipe moves together
    assign adv     = !vld_q[N-1] || ready_i;
    assign ready_o = adv;

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else if (adv) begin
            vld_q <= {vld_q[N-2:0], valid_i};
        end
    end

    always_ff @(posedge aclk) begin
        if (adv) begin
            ll_q      <= ll_d;
            cross_q   <= cross_d;
            tag_q[0]  <= pkt_i.tag;
            dest_q[0] <= pkt_i.dest;
            prod_q[1] <= ll_q + {cross_q, {HALF{1'b0}}}; // final sum
            for (int i = 1; i < N; i++) begin
                tag_q[i]  <= tag_q[i-1];
                dest_q[i] <= dest_q[i-1];
            end
            for (int i = 2; i < N; i++) begin
                prod_q[i] <= prod_q[i-1]; // extra stages only carry
            end
        end
    end

    assign valid_o         = vld_q[N-1];
    assign result_o.w_data = prod_q[N-1];
    assign result_o.dest   = dest_q[N-1];
    assign result_o.tag    = tag_q[N-1];

endmodule

// ==== source/result_queue.sv ====
`include "exec_settings.svh"

module result_queue
    import exec_pkg::*;
#(
    parameter int  DEPTH = `RESULT_QUEUE_DEPTH,
    parameter type T     = cdb_pkt_t
) (
    input  logic aclk,
    input  logic rst_n_i,
    input  logic valid_i,
    input  T     data_i,
    output logic ready_o,
    output logic valid_o,
    output T     data_o,
    input  logic ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             wr_en;
    logic             rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign valid_o = (count_q != '0);
    assign ready_o = (count_q != CNT_W'(DEPTH)); // only full blocks
    assign data_o  = mem_q[rd_ptr_q];            // no bypass from data_i
    assign wr_en   = valid_i && ready_o;
    assign rd_en   = valid_o && ready_i;

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (rd_en) rd_ptr_q <= ptr_inc(rd_ptr_q);
            count_q <= count_q + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) mem_q[wr_ptr_q] <= data_i;
    end

    // count must never wrap either way
    a_no_overflow: assert property (@(posedge aclk) disable iff (!rst_n_i)
        wr_en && !rd_en |=> count_q > $past(count_q) && count_q <= CNT_W'(DEPTH));
    a_no_underflow: assert property (@(posedge aclk) disable iff (!rst_n_i)
        rd_en && !wr_en |=> count_q < $past(count_q));

endmodule

// ==== verif/tb_exec_core.sv ====
`include "exec_settings.svh"

module tb_exec_core
    import exec_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic       aclk;
    logic       rst_n_i;
    logic       alu0_valid_i, alu1_valid_i, mul_valid_i;
    issue_pkt_t alu0_pkt_i, alu1_pkt_i, mul_pkt_i;
    logic       alu0_ready_o, alu1_ready_o, mul_ready_o;
    reg_idx_t   reg_num_i;
    word_t      rf_rdata_o;
    tag_t       debug0_wb_pc_o, debug1_wb_pc_o;
    logic       debug0_wb_rf_wen_o, debug1_wb_rf_wen_o;
    reg_idx_t   debug0_wb_rf_wnum_o, debug1_wb_rf_wnum_o;
    word_t      debug0_wb_rf_wdata_o, debug1_wb_rf_wdata_o;

    logic        lane_valid [3]; // alu0, alu1, mul
    logic        accepted [3];
    issue_pkt_t  lane_pkt [3];
    logic [31:0] lfsr_q;
    word_t       exp_word [int]; // scoreboard by tag
    reg_idx_t    exp_dest [int];
    logic        committed [int];
    word_t       model_rf [`REG_COUNT];
    int          next_tag, issued_cnt, commit_cnt, r0_commits;
    int          val_err_cnt, tag_err_cnt, other_cnt, timeout_cnt;
    int          waited;

    assign alu0_valid_i = lane_valid[0];
    assign alu1_valid_i = lane_valid[1];
    assign mul_valid_i  = lane_valid[2];
    assign alu0_pkt_i   = lane_pkt[0];
    assign alu1_pkt_i   = lane_pkt[1];
    assign mul_pkt_i    = lane_pkt[2];

    exec_core_top dut (.*);

    always #2 aclk = ~aclk;

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t expected_result(input alu_op_e op, input word_t a,
                                              input word_t b, input logic is_mul);
        logic [2*`XLEN-1:0] prod;
        prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
        if (is_mul) return prod[`XLEN-1:0]; // low half only
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
        endcase
    endfunction

    function automatic logic lane_ready(input int l);
        case (l)
            0: return alu0_ready_o;
            1: return alu1_ready_o;
            default: return mul_ready_o;
        endcase
    endfunction

    // held packets stay on their lane until taken
    task automatic issue_step(input logic [2:0] mask, input logic always_on);
        @(negedge aclk);
        for (int l = 0; l < 3; l++) begin
            if (!lane_valid[l] || accepted[l]) begin
                lane_valid[l] = mask[l] && (always_on || rand_bits(1) == 1);
                if (lane_valid[l]) begin
                    lane_pkt[l].op    = alu_op_e'(rand_bits(3));
                    lane_pkt[l].src_a = rand_bits(32);
                    lane_pkt[l].src_b = rand_bits(32);
                    lane_pkt[l].dest  = reg_idx_t'(rand_bits(5));
                    lane_pkt[l].tag   = tag_t'(next_tag);
                    next_tag++;
                end
            end
            accepted[l] = lane_valid[l] && lane_ready(l); // ready ignores valid
            if (accepted[l]) begin
                exp_word[lane_pkt[l].tag] = expected_result(lane_pkt[l].op, lane_pkt[l].src_a,
                                                            lane_pkt[l].src_b, l == 2);
                exp_dest[lane_pkt[l].tag] = lane_pkt[l].dest;
                issued_cnt++;
            end
        end
    endtask

    task automatic check_commit(input tag_t tag, input reg_idx_t wnum, input word_t wdata);
        if (wnum == '0) r0_commits++;
        if (!exp_word.exists(tag)) begin
            $display("commit of tag %0d that was never issued, at %0t", tag, $time);
            tag_err_cnt++;
        end else if (committed.exists(tag)) begin
            $display("tag %0d committed a second time, at %0t", tag, $time);
            tag_err_cnt++;
        end else begin
            committed[tag] = 1'b1;
            commit_cnt++;
            if (wdata !== exp_word[tag]) begin
                $display("[ERROR] %0t: tag %0d wdata %h, expected %h", $time, tag, wdata,
                         exp_word[tag]);
                val_err_cnt++;
            end
            if (wnum !== exp_dest[tag]) begin
                $display("[ERROR] %0t: tag %0d wnum %0d, expected %0d", $time, tag, wnum,
                         exp_dest[tag]);
                val_err_cnt++;
            end
            // replay what this op should leave behind
            if (exp_dest[tag] != '0) model_rf[exp_dest[tag]] = exp_word[tag];
        end
    endtask

    // slot 0 replays before slot 1
    always @(posedge aclk) begin
        if (rst_n_i) begin
            if (debug0_wb_rf_wen_o) check_commit(debug0_wb_pc_o, debug0_wb_rf_wnum_o,
                                                 debug0_wb_rf_wdata_o);
            if (debug1_wb_rf_wen_o) check_commit(debug1_wb_pc_o, debug1_wb_rf_wnum_o,
                                                 debug1_wb_rf_wdata_o);
        end
    end

    task automatic read_reg_check(input int r);
        @(negedge aclk);
        reg_num_i = reg_idx_t'(r);
        #1;
        if (rf_rdata_o !== model_rf[r]) begin
            $display("[ERROR] %0t: r%0d reads %h, expected %h", $time, r, rf_rdata_o,
                     model_rf[r]);
            val_err_cnt++;
        end
    endtask

    initial begin
        aclk      = 1'b0;
        rst_n_i   = 1'b0;
        reg_num_i = '0;
        lfsr_q    = 32'h2154d234;
        for (int l = 0; l < 3; l++) begin
            lane_valid[l] = 1'b0;
            accepted[l]   = 1'b0;
            lane_pkt[l]   = '0;
        end
        for (int r = 0; r < `REG_COUNT; r++) model_rf[r] = '0;

        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst_n_i = 1'b1;
        if (debug0_wb_rf_wen_o || debug1_wb_rf_wen_o) begin
            $display("[ERROR] %0t: debug write enable high after reset", $time);
            val_err_cnt++;
        end
        if (!(alu0_ready_o && alu1_ready_o && mul_ready_o)) begin
            $display("[ERROR] %0t: issue ready low after reset", $time);
            val_err_cnt++;
        end
        for (int r = 0; r < 8; r++) read_reg_check(r * 4 + 1);

        repeat (300) issue_step(3'b011, 1'b0); // alu lanes with random gaps
        repeat (60) issue_step(3'b100, 1'b1);  // mul back to back
        repeat (200) issue_step(3'b111, 1'b1); // full contention

        waited = 0;
        while ((lane_valid[0] || lane_valid[1] || lane_valid[2]) && waited < 100) begin
            issue_step(3'b000, 1'b0);
            waited++;
        end
        if (lane_valid[0] || lane_valid[1] || lane_valid[2]) begin
            $display("timed out waiting for the last issue handshakes");
            timeout_cnt++;
        end
        waited = 0;
        while (commit_cnt < issued_cnt && waited < 200) begin
            @(negedge aclk);
            waited++;
        end
        if (commit_cnt < issued_cnt) begin
            $display("drain timed out, %0d of %0d tags never committed",
                     issued_cnt - commit_cnt, issued_cnt);
            timeout_cnt++;
        end
        repeat (4) @(negedge aclk); // catch stray commits
        for (int r = 0; r < `REG_COUNT; r++) read_reg_check(r);
        if (r0_commits == 0) begin
            $display("no write to r0 was seen on the debug ports");
            other_cnt++;
        end

        $display("issued %0d, committed %0d, errors: %0d value, %0d tag, %0d other, %0d timeout",
                 issued_cnt, commit_cnt, val_err_cnt, tag_err_cnt, other_cnt, timeout_cnt);
        if (val_err_cnt + tag_err_cnt + other_cnt + timeout_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
